//--- Bender.yml
package:
  name: cache_unified

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cache_pkg.sv
      - verilog/cache_core.sv
      - verilog/cache_nocache.sv
      - verilog/cache_sync.sv
      - verilog/cache_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/cache_checker.sv
      - dv/cache_tb.sv

//--- dv/cache_checker.sv
// bus and acknowledge checker for the cache top
// reset, handshake hold and pulse width rules as assertions
`timescale 1ns/100ps
`default_nettype none

module cache_checker import cache_pkg::*; (
  input logic   clk,
  input logic   i_arst_n,
  input logic   i_icache_ack,
  input logic   i_dcache_ack,
  input logic   i_fencei_ack,
  input logic   i_bus_valid,
  input logic   i_bus_ready,
  input logic   i_bus_op,
  input addr_t  i_bus_addr,
  input bytes_t i_bus_size,
  input blks_t  i_bus_blks,
  input line_t  i_bus_wdata
);

  int unsigned fail_cnt = 0;

  property one_cycle(logic ack);
    @(posedge clk) disable iff (!i_arst_n) ack |=> !ack;
  endproperty

  reset_quiet: assert property (@(posedge clk)
    !i_arst_n |-> !(i_bus_valid || i_icache_ack || i_dcache_ack || i_fencei_ack))
    else begin
      fail_cnt++;
      $error("bus valid or an ack high during reset");
    end

  // a waiting transfer keeps its fields
  valid_held: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_bus_valid && !i_bus_ready |=> i_bus_valid &&
      $stable({i_bus_op, i_bus_addr, i_bus_size, i_bus_blks, i_bus_wdata}))
    else begin
      fail_cnt++;
      $error("bus fields changed before ready");
    end

  iack_pulse: assert property (one_cycle(i_icache_ack))
    else begin
      fail_cnt++;
      $error("instruction ack longer than one cycle");
    end

  dack_pulse: assert property (one_cycle(i_dcache_ack))
    else begin
      fail_cnt++;
      $error("data ack longer than one cycle");
    end

  fack_pulse: assert property (one_cycle(i_fencei_ack))
    else begin
      fail_cnt++;
      $error("fence ack longer than one cycle");
    end

endmodule

bind cache_top cache_checker top_checker (
  .clk          (clk),
  .i_arst_n     (i_arst_n),
  .i_icache_ack (o_icache_ack),
  .i_dcache_ack (o_dcache_ack),
  .i_fencei_ack (o_fencei_ack),
  .i_bus_valid  (o_bus_valid),
  .i_bus_ready  (i_bus_ready),
  .i_bus_op     (o_bus_op),
  .i_bus_addr   (o_bus_addr),
  .i_bus_size   (o_bus_size),
  .i_bus_blks   (o_bus_blks),
  .i_bus_wdata  (o_bus_wdata)
);

`default_nettype wire

//--- dv/cache_tb.sv
// cache interface testbench
// random traffic on all ports against a byte reference and a bus memory model
`timescale 1ns/100ps
`default_nettype none
`include "cache_defines.svh"

module cache_tb import cache_pkg::*; ();

  localparam int CLK_NS  = 8;
  localparam int N_RAND  = 200;
  localparam int N_FETCH = 60;
  localparam int N_PERI  = 40;
  localparam int N_CODE  = 24;
  localparam int N_BP    = 60;
  // cold miss and fence.i count as one op each
  localparam int N_OPS   = 2 + N_RAND + N_FETCH + N_PERI + 2 * N_CODE + N_BP;
  localparam addr_t LINE_MASK = ~addr_t'(`CACHE_LINE_BYTES - 1);

  logic   clk, i_arst_n;
  logic   i_icache_req, o_icache_ack;
  addr_t  i_icache_addr;
  inst_t  o_icache_rdata;
  logic   i_dcache_req, i_dcache_op, o_dcache_ack;
  addr_t  i_dcache_addr;
  bytes_t i_dcache_bytes;
  word_t  i_dcache_wdata, o_dcache_rdata;
  logic   i_fencei_req, o_fencei_ack;
  logic   i_bus_ready, o_bus_valid, o_bus_op;
  line_t  i_bus_rdata, o_bus_wdata;
  addr_t  o_bus_addr;
  bytes_t o_bus_size;
  blks_t  o_bus_blks;

  // memory model and transfer log
  line_t       mem [addr_t];
  logic [7:0]  ref_bytes [addr_t];
  int unsigned min_delay;
  int unsigned max_spread;
  int unsigned xfer_cnt;
  logic        last_op;
  addr_t       last_addr;
  bytes_t      last_size;
  blks_t       last_blks;
  word_t       last_wdata;
  word_t       last_rdata;

  cache_top cache_top_inst (.*);

  always #(CLK_NS / 2) clk = ~clk;

  function automatic word_t fill_word(input addr_t a);
    return (a * 64'h9e37_79b9_7f4a_7c15) ^ {a[31:0], ~a[63:32]};
  endfunction

  function automatic line_t mem_line(input addr_t la);
    line_t l;
    int    w;
    if (mem.exists(la)) begin
      return mem[la];
    end
    for (w = 0; w < 8; w++) begin
      l[w*64 +: 64] = fill_word(la + addr_t'(8 * w));
    end
    return l;
  endfunction

  function automatic word_t mem_word(input addr_t a);
    line_t l;
    l = mem_line(a & LINE_MASK);
    return l[a[5:3]*64 +: 64];
  endfunction

  // aligned word as the core sees it after every write so far
  function automatic word_t ref_word(input addr_t a);
    addr_t wa;
    addr_t ba;
    word_t w;
    int    b;
    wa = {a[63:3], 3'b000};
    w  = fill_word(wa);
    for (b = 0; b < 8; b++) begin
      ba = wa + addr_t'(b);
      if (ref_bytes.exists(ba)) begin
        w[8*b +: 8] = ref_bytes[ba];
      end
    end
    return w;
  endfunction

  function automatic inst_t pick_inst(input word_t w, input addr_t a);
    return a[2] ? w[63:32] : w[31:0];
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      stop_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_inst(input string name, input inst_t exp, input inst_t act);
    if (act !== exp) begin
      stop_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_bus(input string name, input blks_t exp, input blks_t act);
    if (act !== exp) begin
      stop_run($sformatf("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  task automatic data_access(input logic op, input addr_t a, input bytes_t sz,
                             input word_t wd, output word_t rd);
    int b;
    @(negedge clk);
    i_dcache_req   = 1'b1;
    i_dcache_addr  = a;
    i_dcache_op    = op;
    i_dcache_bytes = sz;
    i_dcache_wdata = wd;
    do @(negedge clk); while (!o_dcache_ack);
    rd           = o_dcache_rdata;
    i_dcache_req = 1'b0;
    if (op == `REQ_WRITE) begin
      for (b = 0; b < (1 << sz); b++) begin
        ref_bytes[a + addr_t'(b)] = wd[8*b +: 8];
      end
    end
  endtask

  task automatic fetch_inst(input addr_t a, output inst_t rd);
    @(negedge clk);
    i_icache_req  = 1'b1;
    i_icache_addr = a;
    do @(negedge clk); while (!o_icache_ack);
    rd           = o_icache_rdata;
    i_icache_req = 1'b0;
  endtask

  task automatic run_fence();
    @(negedge clk);
    i_fencei_req = 1'b1;
    do @(negedge clk); while (!o_fencei_ack);
    i_fencei_req = 1'b0;
  endtask

  // a few lines on two indexes, four tags each
  task automatic random_data(input int n);
    int     i;
    logic   op;
    addr_t  a;
    bytes_t sz;
    word_t  wd;
    word_t  rd;
    word_t  exp;
    for (i = 0; i < n; i++) begin
      sz  = bytes_t'($urandom_range(3));
      a   = 64'h8000_0000 + 64'h400 * $urandom_range(3) + 64'h40 * $urandom_range(2, 1)
            + $urandom_range(63);
      a   = a & ~((addr_t'(1) << sz) - 1);
      op  = 1'($urandom_range(1));
      wd  = {$urandom, $urandom};
      exp = ref_word(a);
      data_access(op, a, sz, wd, rd);
      if (op == `REQ_READ) begin
        check_word("data read", exp, rd);
      end
    end
  endtask

  ////////////////////////////////////////
  // bus responder
  initial begin : bus_model
    int unsigned gap;
    logic        op;
    addr_t       a;
    bytes_t      sz;
    blks_t       bl;
    line_t       wd;
    line_t       rd;
    forever begin
      @(negedge clk);
      i_bus_ready = 1'b0;
      if (i_arst_n && o_bus_valid) begin
        op  = o_bus_op;
        a   = o_bus_addr;
        sz  = o_bus_size;
        bl  = o_bus_blks;
        wd  = o_bus_wdata;
        gap = min_delay + $urandom_range(max_spread);
        repeat (gap) @(negedge clk);
        rd = '0;
        if (bl == `BUS_BLKS_LINE) begin
          check_bus("line size code", blks_t'(3), blks_t'(sz));
          check_word("line address", a & LINE_MASK, a);
          if (op == `REQ_WRITE) begin
            mem[a] = wd;
          end else begin
            rd = mem_line(a);
          end
        end else if (op == `REQ_READ) begin
          rd[63:0] = {$urandom, $urandom};
        end
        last_op     = op;
        last_addr   = a;
        last_size   = sz;
        last_blks   = bl;
        last_wdata  = wd[63:0];
        last_rdata  = rd[63:0];
        xfer_cnt    = xfer_cnt + 1;
        i_bus_rdata = rd;
        i_bus_ready = 1'b1;
      end
    end
  end

  // acks only once the bus has gone quiet
  always @(negedge clk) begin
    if (i_arst_n && o_bus_valid && (o_icache_ack || o_dcache_ack)) begin
      stop_run("an ack came while a bus transfer still waited for ready");
    end
    if (cache_top_inst.top_checker.fail_cnt != 0) begin
      stop_run("a bus or ack assertion failed");
    end
  end

  initial begin : watchdog
    #(N_OPS * 2000 * CLK_NS);
    stop_run("timeout, the DUT stopped answering");
  end

  ////////////////////////////////////////
  // stimulus
  initial begin : stimulus
    int          i;
    int unsigned n0;
    logic        op;
    addr_t       a;
    bytes_t      sz;
    word_t       wd;
    word_t       rd;
    inst_t       inst;
    void'($urandom(32'ha12a));
    clk            = 1'b0;
    i_arst_n       = 1'b1;
    i_icache_req   = 1'b0;
    i_icache_addr  = '0;
    i_dcache_req   = 1'b0;
    i_dcache_addr  = '0;
    i_dcache_op    = `REQ_READ;
    i_dcache_bytes = '0;
    i_dcache_wdata = '0;
    i_fencei_req   = 1'b0;
    i_bus_ready    = 1'b0;
    i_bus_rdata    = '0;
    min_delay      = 0;
    max_spread     = 3;
    xfer_cnt       = 0;
    #1;
    i_arst_n = 1'b0;
    repeat (3) @(negedge clk);
    i_arst_n = 1'b1;
    if (o_bus_valid || o_icache_ack || o_dcache_ack || o_fencei_ack) begin
      stop_run("bus valid or an ack is high right after reset");
    end

    // valid bits cleared, so the first read is one clean refill
    n0 = xfer_cnt;
    data_access(`REQ_READ, 64'h8000_0040, bytes_t'(3), '0, rd);
    check_bus("cold miss transfers", blks_t'(1), blks_t'(xfer_cnt - n0));
    check_word("cold miss data", ref_word(64'h8000_0040), rd);

    random_data(N_RAND);

    // fetches from memory and flash lines the data port never wrote
    for (i = 0; i < N_FETCH; i++) begin
      a = ($urandom_range(1) == 1) ? {32'd0, `REGION_FLASH, 28'd0} : 64'h8004_0000;
      a = a + 64'h400 * $urandom_range(1) + 4 * $urandom_range(255);
      fetch_inst(a, inst);
      check_inst("fetch", pick_inst(mem_word(a), a), inst);
    end

    // peripheral space on either port
    for (i = 0; i < N_PERI; i++) begin
      a  = {32'd0, 4'(`REGION_PERI_LO + $urandom_range(1)), 28'($urandom)};
      n0 = xfer_cnt;
      if ($urandom_range(1) == 1) begin
        sz = bytes_t'(2);
        op = `REQ_READ;
        a  = a & ~addr_t'(3);
        fetch_inst(a, inst);
        check_inst("peripheral fetch", last_rdata[31:0], inst);
      end else begin
        sz = bytes_t'($urandom_range(3));
        op = 1'($urandom_range(1));
        a  = a & ~((addr_t'(1) << sz) - 1);
        wd = {$urandom, $urandom};
        data_access(op, a, sz, wd, rd);
        if (op == `REQ_READ) begin
          check_word("peripheral read", last_rdata, rd);
        end else begin
          check_word("peripheral write data", wd, last_wdata);
        end
      end
      check_bus("peripheral transfers", blks_t'(1), blks_t'(xfer_cnt - n0));
      check_bus("peripheral blks", blks_t'(0), last_blks);
      check_bus("peripheral size", blks_t'(sz), blks_t'(last_size));
      check_bus("peripheral op", blks_t'(op), blks_t'(last_op));
      check_word("peripheral address", a, last_addr);
    end

    // new code through the data port, then fence.i
    for (i = 0; i < N_CODE; i++) begin
      a = 64'h8008_0000 + 64'h40 * $urandom_range(11, 8) + 4 * $urandom_range(15);
      data_access(`REQ_WRITE, a, bytes_t'(2), {$urandom, $urandom}, rd);
    end
    run_fence();
    for (i = 0; i < N_CODE; i++) begin
      a = 64'h8008_0000 + 64'h40 * $urandom_range(11, 8) + 4 * $urandom_range(15);
      fetch_inst(a, inst);
      check_inst("fetch after fence.i", pick_inst(ref_word(a), a), inst);
    end

    // long ready delays
    min_delay  = 12;
    max_spread = 24;
    random_data(N_BP);

    repeat (4) @(negedge clk);
    if (cache_top_inst.top_checker.fail_cnt != 0) begin
      stop_run("a bus or ack assertion failed");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+verilog
verilog/cache_pkg.sv
verilog/cache_core.sv
verilog/cache_nocache.sv
verilog/cache_sync.sv
verilog/cache_top.sv
dv/cache_checker.sv
dv/cache_tb.sv

//--- verilog/cache_core.sv
// direct-mapped write-back cache core
// one-cycle hits, writeback and refill on miss, line sync port for fence.i
`timescale 1ns/100ps
`default_nettype none
`include "cache_defines.svh"

module cache_core import cache_pkg::*; (
  input  logic    clk,
  input  logic    i_arst_n,
  input  logic    i_req,
  input  addr_t   i_addr,
  input  logic    i_op,
  input  bytes_t  i_bytes,
  input  word_t   i_wdata,
  output logic    o_ack,
  output word_t   o_rdata,
  input  logic    i_sync_rreq,
  input  logic    i_sync_wreq,
  input  idx_t    i_sync_idx,
  input  info_t   i_sync_winfo,
  input  line_t   i_sync_wline,
  output logic    o_sync_ack,
  output info_t   o_sync_rinfo,
  output line_t   o_sync_rline,
  input  logic    i_bus_ready,
  input  line_t   i_bus_rdata,
  output logic    o_bus_valid,
  output logic    o_bus_op,
  output addr_t   o_bus_addr,
  output line_t   o_bus_wline,
  output blks_t   o_bus_blks
);

  localparam int OFF_W   = $clog2(`CACHE_LINE_BYTES);
  localparam int TAG_LSB = OFF_W + `CACHE_IDX_W;

  core_state_t             state_q;
  tag_t                    tag_q  [`CACHE_LINES];
  line_t                   line_q [`CACHE_LINES];
  logic [`CACHE_LINES-1:0] valid_q;
  logic [`CACHE_LINES-1:0] dirty_q;

  idx_t             req_idx;
  tag_t             req_tag;
  logic [OFF_W-4:0] req_woff;
  logic             hit;
  logic             hit_go;
  logic             fill_go;
  logic             srd_go;
  word_t            word_old;
  word_t            word_new;
  word_t            size_mask;
  word_t            bit_mask;
  word_t            wdata_sh;

  assign req_idx  = i_addr[OFF_W +: `CACHE_IDX_W];
  assign req_tag  = i_addr[31:TAG_LSB];
  assign req_woff = i_addr[OFF_W-1:3];
  assign hit      = valid_q[req_idx] && (tag_q[req_idx] == req_tag);

  assign hit_go  = (state_q == C_IDLE) && i_req && hit;
  assign fill_go = (state_q == C_REFILL) && i_bus_ready;
  assign srd_go  = (state_q == C_IDLE) && !i_req && i_sync_rreq;

  // byte-masked merge of the store into the addressed word
  always_comb begin
    word_old  = line_q[req_idx][{req_woff, 6'd0} +: 64];
    size_mask = (word_t'(1) << (8 << i_bytes)) - word_t'(1);
    bit_mask  = size_mask << {i_addr[2:0], 3'b000};
    wdata_sh  = i_wdata << {i_addr[2:0], 3'b000};
    word_new  = (word_old & ~bit_mask) | (wdata_sh & bit_mask);
  end

  // victim writeback uses the stored tag, refill the request address
  assign o_bus_valid = (state_q == C_WBACK) || (state_q == C_REFILL);
  assign o_bus_op    = (state_q == C_WBACK) ? `REQ_WRITE : `REQ_READ;
  assign o_bus_addr  = (state_q == C_WBACK) ?
                       {32'd0, tag_q[req_idx], req_idx, {OFF_W{1'b0}}} :
                       {i_addr[63:OFF_W], {OFF_W{1'b0}}};
  assign o_bus_wline = line_q[req_idx];
  assign o_bus_blks  = `BUS_BLKS_LINE;

  ////////////////////////////////////////
  // control FSM
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q    <= C_IDLE;
      o_ack      <= 1'b0;
      o_sync_ack <= 1'b0;
      valid_q    <= '0;
      dirty_q    <= '0;
    end else begin
      o_ack      <= 1'b0;
      o_sync_ack <= 1'b0;
      case (state_q)
        C_IDLE: begin
          if (i_req) begin
            if (hit) begin
              o_ack   <= 1'b1;
              state_q <= C_RESP;
              if (i_op == `REQ_WRITE) begin
                dirty_q[req_idx] <= 1'b1;
              end
            end else if (valid_q[req_idx] && dirty_q[req_idx]) begin
              state_q <= C_WBACK;
            end else begin
              state_q <= C_REFILL;
            end
          end else if (i_sync_rreq) begin
            o_sync_ack <= 1'b1;
            state_q    <= C_RESP;
          end else if (i_sync_wreq) begin
            state_q <= C_SYNC_WR;
          end
        end
        C_WBACK: begin
          if (i_bus_ready) begin
            dirty_q[req_idx] <= 1'b0;
            state_q          <= C_REFILL;
          end
        end
        C_REFILL: begin
          // back to idle, the held request then hits
          if (i_bus_ready) begin
            valid_q[req_idx] <= 1'b1;
            dirty_q[req_idx] <= 1'b0;
            state_q          <= C_IDLE;
          end
        end
        C_SYNC_WR: begin
          valid_q[i_sync_idx] <= i_sync_winfo[1];
          dirty_q[i_sync_idx] <= 1'b0;
          o_sync_ack          <= 1'b1;
          state_q             <= C_RESP;
        end
        C_RESP: state_q <= C_IDLE;
        default: state_q <= C_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // tag and line arrays
  always_ff @(posedge clk) begin
    if (hit_go) begin
      o_rdata <= word_old;
      if (i_op == `REQ_WRITE) begin
        line_q[req_idx][{req_woff, 6'd0} +: 64] <= word_new;
      end
    end
    if (fill_go) begin
      line_q[req_idx] <= i_bus_rdata;
      tag_q[req_idx]  <= req_tag;
    end
    if (srd_go) begin
      o_sync_rinfo <= {tag_q[i_sync_idx], valid_q[i_sync_idx], dirty_q[i_sync_idx]};
      o_sync_rline <= line_q[i_sync_idx];
    end
    if (state_q == C_SYNC_WR) begin
      tag_q[i_sync_idx]  <= i_sync_winfo[$bits(info_t)-1:2];
      line_q[i_sync_idx] <= i_sync_wline;
    end
  end

endmodule

`default_nettype wire

//--- verilog/cache_defines.svh
// unified cache defines
// geometry, bus op codes and address region codes
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// cache geometry
`define CACHE_IDX_W       4
`define CACHE_LINES       16
`define CACHE_LINE_BYTES  64

// op codes on the data port and the bus
`define REQ_READ          1'b0
`define REQ_WRITE         1'b1

// address bits 31:28
`define REGION_PERI_LO    4'h1
`define REGION_PERI_HI    4'h2
`define REGION_FLASH      4'h3

// beats minus one for a full line transfer
`define BUS_BLKS_LINE     8'd7

`endif

//--- verilog/cache_nocache.sv
// uncached access path
// single-beat bus transfer for peripheral requests
`timescale 1ns/100ps
`default_nettype none
`include "cache_defines.svh"

module cache_nocache import cache_pkg::*; (
  input  logic    clk,
  input  logic    i_arst_n,
  input  logic    i_req,
  input  addr_t   i_addr,
  input  logic    i_op,
  input  bytes_t  i_bytes,
  input  word_t   i_wdata,
  output logic    o_ack,
  output word_t   o_rdata,
  input  logic    i_bus_ready,
  input  line_t   i_bus_rdata,
  output logic    o_bus_valid,
  output logic    o_bus_op,
  output addr_t   o_bus_addr,
  output bytes_t  o_bus_size,
  output line_t   o_bus_wdata
);

  logic   busy_q;
  logic   take;
  logic   op_q;
  addr_t  addr_q;
  bytes_t size_q;
  word_t  wdata_q;

  // no new capture during the ack cycle
  assign take = i_req && !busy_q && !o_ack;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      busy_q <= 1'b0;
      o_ack  <= 1'b0;
    end else begin
      o_ack <= 1'b0;
      if (busy_q && i_bus_ready) begin
        busy_q <= 1'b0;
        o_ack  <= 1'b1;
      end else if (take) begin
        busy_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      addr_q  <= i_addr;
      op_q    <= i_op;
      size_q  <= i_bytes;
      wdata_q <= i_wdata;
    end
    if (busy_q && i_bus_ready && (op_q == `REQ_READ)) begin
      o_rdata <= i_bus_rdata[63:0];
    end
  end

  assign o_bus_valid = busy_q;
  assign o_bus_op    = op_q;
  assign o_bus_addr  = addr_q;
  assign o_bus_size  = size_q;
  assign o_bus_wdata = line_t'(wdata_q);

endmodule

`default_nettype wire

//--- verilog/cache_pkg.sv
// unified cache types
// vector widths and FSM encodings shared by the cache blocks
`default_nettype none
`include "cache_defines.svh"

package cache_pkg;

  typedef logic [63:0]                      addr_t;
  typedef logic [63:0]                      word_t;
  typedef logic [31:0]                      inst_t;
  typedef logic [`CACHE_LINE_BYTES*8-1:0]   line_t;
  typedef logic [2:0]                       bytes_t;
  typedef logic [7:0]                       blks_t;
  typedef logic [`CACHE_IDX_W-1:0]          idx_t;
  typedef logic [21:0]                      tag_t;
  // tag, valid, dirty from msb down
  typedef logic [$bits(tag_t)+1:0]          info_t;

  typedef enum logic [2:0] {C_IDLE, C_WBACK, C_REFILL, C_RESP, C_SYNC_WR} core_state_t;
  typedef enum logic [2:0] {S_IDLE, S_RD, S_WR, S_NEXT, S_DONE} sync_state_t;

endpackage

`default_nettype wire

//--- verilog/cache_sync.sv
// fence.i sync engine
// copies each valid data-cache line into the same instruction-cache index
`timescale 1ns/100ps
`default_nettype none
`include "cache_defines.svh"

module cache_sync import cache_pkg::*; (
  input  logic  clk,
  input  logic  i_arst_n,
  input  logic  i_fencei_req,
  output logic  o_fencei_ack,
  output logic  o_dsync_rreq,
  input  logic  i_dsync_ack,
  input  info_t i_dsync_rinfo,
  input  line_t i_dsync_rline,
  output logic  o_isync_wreq,
  input  logic  i_isync_ack,
  output idx_t  o_sync_idx,
  output info_t o_isync_winfo,
  output line_t o_isync_wline
);

  localparam idx_t LAST_IDX = idx_t'(`CACHE_LINES - 1);

  sync_state_t state_q;
  idx_t        idx_q;

  assign o_dsync_rreq = (state_q == S_RD);
  assign o_isync_wreq = (state_q == S_WR);
  assign o_sync_idx   = idx_q;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q      <= S_IDLE;
      idx_q        <= '0;
      o_fencei_ack <= 1'b0;
    end else begin
      o_fencei_ack <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (i_fencei_req) begin
            idx_q   <= '0;
            state_q <= S_RD;
          end
        end
        // invalid lines are skipped
        S_RD: begin
          if (i_dsync_ack) begin
            state_q <= i_dsync_rinfo[1] ? S_WR : S_NEXT;
          end
        end
        S_WR: begin
          if (i_isync_ack) begin
            state_q <= S_NEXT;
          end
        end
        S_NEXT: begin
          if (idx_q == LAST_IDX) begin
            o_fencei_ack <= 1'b1;
            state_q      <= S_DONE;
          end else begin
            idx_q   <= idx_q + 1'b1;
            state_q <= S_RD;
          end
        end
        S_DONE: state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // line copy, dirty bit dropped
  always_ff @(posedge clk) begin
    if ((state_q == S_RD) && i_dsync_ack) begin
      o_isync_winfo <= {i_dsync_rinfo[$bits(info_t)-1:1], 1'b0};
      o_isync_wline <= i_dsync_rline;
    end
  end

endmodule

`default_nettype wire

//--- verilog/cache_top.sv
// unified cache interface top
// region decode, request routing and bus arbitration for both caches
`timescale 1ns/100ps
`default_nettype none
`include "cache_defines.svh"

module cache_top import cache_pkg::*; (
  input  logic    clk,
  input  logic    i_arst_n,
  input  logic    i_icache_req,
  input  addr_t   i_icache_addr,
  output logic    o_icache_ack,
  output inst_t   o_icache_rdata,
  input  logic    i_dcache_req,
  input  addr_t   i_dcache_addr,
  input  logic    i_dcache_op,
  input  bytes_t  i_dcache_bytes,
  input  word_t   i_dcache_wdata,
  output logic    o_dcache_ack,
  output word_t   o_dcache_rdata,
  input  logic    i_fencei_req,
  output logic    o_fencei_ack,
  input  logic    i_bus_ready,
  input  line_t   i_bus_rdata,
  output logic    o_bus_valid,
  output logic    o_bus_op,
  output addr_t   o_bus_addr,
  output bytes_t  o_bus_size,
  output blks_t   o_bus_blks,
  output line_t   o_bus_wdata
);

  function automatic logic is_peri(input addr_t addr);
    return (addr[31:28] == `REGION_PERI_LO) || (addr[31:28] == `REGION_PERI_HI);
  endfunction

  function automatic logic is_cached(input addr_t addr);
    return (addr[31:28] == `REGION_FLASH) || addr[31];
  endfunction

  logic   ch_icache, ch_dcache, nc_sel_i, nc_req;
  logic   nc_own_i_q, iaddr2_q;
  logic   ic_ack, dc_ack, nc_ack;
  logic   ic_valid, dc_valid, nc_valid;
  logic   ic_op, dc_op, nc_op;
  word_t  ic_rdata, dc_rdata, nc_rdata;
  addr_t  ic_addr, dc_addr, nc_addr;
  line_t  ic_wline, dc_wline, nc_wdata;
  blks_t  ic_blks, dc_blks;
  bytes_t nc_size;
  logic   dsync_rreq, dsync_ack, isync_wreq, isync_ack;
  idx_t   sync_idx;
  info_t  dsync_rinfo, isync_winfo;
  line_t  dsync_rline, isync_wline;

  ////////////////////////////////////////
  // routing
  assign ch_icache = i_icache_req && is_cached(i_icache_addr);
  assign ch_dcache = i_dcache_req && is_cached(i_dcache_addr);
  assign nc_sel_i  = i_icache_req && is_peri(i_icache_addr);
  assign nc_req    = nc_sel_i || (i_dcache_req && is_peri(i_dcache_addr));

  // which port the uncached ack belongs to
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      nc_own_i_q <= 1'b0;
    end else if (nc_req) begin
      nc_own_i_q <= nc_sel_i;
    end
  end

  always_ff @(posedge clk) begin
    if (i_icache_req) begin
      iaddr2_q <= i_icache_addr[2];
    end
  end

  cache_core icache_core (
    .clk (clk), .i_arst_n (i_arst_n),
    .i_req (ch_icache), .i_addr (i_icache_addr), .i_op (`REQ_READ),
    .i_bytes (bytes_t'(3)), .i_wdata ('0), .o_ack (ic_ack), .o_rdata (ic_rdata),
    .i_sync_rreq (1'b0), .i_sync_wreq (isync_wreq), .i_sync_idx (sync_idx),
    .i_sync_winfo (isync_winfo), .i_sync_wline (isync_wline), .o_sync_ack (isync_ack),
    .o_sync_rinfo (), .o_sync_rline (),
    .i_bus_ready (ch_icache && i_bus_ready), .i_bus_rdata (i_bus_rdata),
    .o_bus_valid (ic_valid), .o_bus_op (ic_op), .o_bus_addr (ic_addr),
    .o_bus_wline (ic_wline), .o_bus_blks (ic_blks)
  );

  cache_core dcache_core (
    .clk (clk), .i_arst_n (i_arst_n),
    .i_req (ch_dcache), .i_addr (i_dcache_addr), .i_op (i_dcache_op),
    .i_bytes (i_dcache_bytes), .i_wdata (i_dcache_wdata), .o_ack (dc_ack), .o_rdata (dc_rdata),
    .i_sync_rreq (dsync_rreq), .i_sync_wreq (1'b0), .i_sync_idx (sync_idx),
    .i_sync_winfo ('0), .i_sync_wline ('0), .o_sync_ack (dsync_ack),
    .o_sync_rinfo (dsync_rinfo), .o_sync_rline (dsync_rline),
    .i_bus_ready (!ch_icache && ch_dcache && i_bus_ready), .i_bus_rdata (i_bus_rdata),
    .o_bus_valid (dc_valid), .o_bus_op (dc_op), .o_bus_addr (dc_addr),
    .o_bus_wline (dc_wline), .o_bus_blks (dc_blks)
  );

  cache_nocache nocache_path (
    .clk (clk), .i_arst_n (i_arst_n), .i_req (nc_req),
    .i_addr (nc_sel_i ? i_icache_addr : i_dcache_addr),
    .i_op (nc_sel_i ? `REQ_READ : i_dcache_op),
    .i_bytes (nc_sel_i ? bytes_t'(2) : i_dcache_bytes),
    .i_wdata (nc_sel_i ? '0 : i_dcache_wdata),
    .o_ack (nc_ack), .o_rdata (nc_rdata),
    .i_bus_ready (!ch_icache && !ch_dcache && i_bus_ready), .i_bus_rdata (i_bus_rdata),
    .o_bus_valid (nc_valid), .o_bus_op (nc_op), .o_bus_addr (nc_addr),
    .o_bus_size (nc_size), .o_bus_wdata (nc_wdata)
  );

  cache_sync sync_engine (
    .clk (clk), .i_arst_n (i_arst_n),
    .i_fencei_req (i_fencei_req), .o_fencei_ack (o_fencei_ack),
    .o_dsync_rreq (dsync_rreq), .i_dsync_ack (dsync_ack),
    .i_dsync_rinfo (dsync_rinfo), .i_dsync_rline (dsync_rline),
    .o_isync_wreq (isync_wreq), .i_isync_ack (isync_ack), .o_sync_idx (sync_idx),
    .o_isync_winfo (isync_winfo), .o_isync_wline (isync_wline)
  );

  ////////////////////////////////////////
  // bus owner: icache, then dcache, then uncached
  always_comb begin
    if (ch_icache) begin
      {o_bus_valid, o_bus_op, o_bus_addr} = {ic_valid, ic_op, ic_addr};
      {o_bus_wdata, o_bus_size, o_bus_blks} = {ic_wline, bytes_t'(3), ic_blks};
    end else if (ch_dcache) begin
      {o_bus_valid, o_bus_op, o_bus_addr} = {dc_valid, dc_op, dc_addr};
      {o_bus_wdata, o_bus_size, o_bus_blks} = {dc_wline, bytes_t'(3), dc_blks};
    end else begin
      {o_bus_valid, o_bus_op, o_bus_addr} = {nc_valid, nc_op, nc_addr};
      {o_bus_wdata, o_bus_size, o_bus_blks} = {nc_wdata, nc_size, blks_t'(0)};
    end
  end

  // responses
  assign o_icache_ack   = ic_ack || (nc_ack && nc_own_i_q);
  assign o_icache_rdata = ic_ack ? (iaddr2_q ? ic_rdata[63:32] : ic_rdata[31:0]) :
                          nc_rdata[31:0];
  assign o_dcache_ack   = dc_ack || (nc_ack && !nc_own_i_q);
  assign o_dcache_rdata = dc_ack ? dc_rdata : nc_rdata;

endmodule

`default_nettype wire
